// File: design/stomp_config.svh
// =========================================================================
// stomp core configuration
// sizes of the pc, the sequence number, the front end and the reorder buffer
// =========================================================================

`ifndef STOMP_CONFIG_SVH
`define STOMP_CONFIG_SVH

// width of an instruction-group address
`define STOMP_PC_W 16

// width of the fetch sequence number
// test runs stay short enough that it never wraps
`define STOMP_SN_W 8

// number of front-end stages (fetch, mux, decode, rename)
`define STOMP_STAGES 4

// reorder-buffer depth, kept a power of two so the pointers wrap by themselves
`define STOMP_ROB_ENTRIES 8

`endif

// File: design/stomp_pkg.sv
// =========================================================================
// stomp package
// common types for the front end and the reorder buffer
// =========================================================================

`include "stomp_config.svh"

package stomp_pkg;

	// instruction-group address
	typedef logic [`STOMP_PC_W-1:0] pc_t;

	// fetch sequence number
	// a larger value is a younger item, the whole core shares one counter
	typedef logic [`STOMP_SN_W-1:0] sn_t;

	// slot index inside the reorder buffer
	typedef logic [$clog2(`STOMP_ROB_ENTRIES)-1:0] rob_ndx_t;

	// state of one reorder-buffer slot
	// a stomped entry still commits so its register mappings can be backed out
	typedef enum logic [1:0] {
		ENT_EMPTY   = 2'd0,
		ENT_LIVE    = 2'd1,
		ENT_STOMPED = 2'd2
	} rob_state_e;

endpackage

// File: design/fetch_redirect.sv
// =========================================================================
// fetch address and sequence-number generator
// emits one instruction group per step and redirects to the miss address
// =========================================================================

`timescale 1ns/100ps

module fetch_redirect (
	input  logic           clk,
	input  logic           rst,
	input  logic           step,
	input  logic           branch_miss,
	input  stomp_pkg::pc_t miss_pc,
	output logic           out_valid,
	output stomp_pkg::pc_t out_pc,
	output stomp_pkg::sn_t out_sn
);

	import stomp_pkg::*;

	// address of the next group to fetch
	pc_t pc_q;
	// sequence number the next fetched group gets
	sn_t sn_q;

	// a fetch happens on a step edge that carries no miss
	logic do_fetch;

	assign do_fetch = step && !branch_miss;

	// =====================================================================
	// pc and sequence counter
	// =====================================================================

	// the miss wins over a step in the same cycle
	// the sn counter is never rewound, so age compares stay global
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= '0;
			sn_q <= '0;
		end else if (branch_miss) begin
			pc_q <= miss_pc;
		end else if (do_fetch) begin
			pc_q <= pc_q + 1'b1;
			sn_q <= sn_q + 1'b1;
		end
	end

	// =====================================================================
	// fetch output register
	// =====================================================================

	// valid bit of the group handed to stage 0
	// a miss empties it, the group there would be stomped anyway
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (branch_miss) begin
			out_valid <= 1'b0;
		end else if (step) begin
			out_valid <= 1'b1;
		end
	end

	// payload of the fetched group, only meaningful while out_valid is high
	always_ff @(posedge clk) begin
		if (do_fetch) begin
			out_pc <= pc_q;
			out_sn <= sn_q;
		end
	end

endmodule

// File: design/frontend_stage.sv
// =========================================================================
// front-end pipeline stage
// holds one instruction group and its stomp bit and stomps it on a miss
// =========================================================================

`timescale 1ns/100ps

module frontend_stage (
	input  logic           clk,
	input  logic           rst,
	input  logic           step,
	input  logic           branch_miss,
	input  logic           in_valid,
	input  stomp_pkg::pc_t in_pc,
	input  stomp_pkg::sn_t in_sn,
	input  logic           in_stomp,
	output logic           out_valid,
	output stomp_pkg::pc_t out_pc,
	output stomp_pkg::sn_t out_sn,
	output logic           out_stomp
);

	import stomp_pkg::*;

	// registered group held by this stage
	logic valid_q;
	logic stomp_q;
	pc_t  pc_q;
	sn_t  sn_q;

	// =====================================================================
	// valid and stomp bits
	// =====================================================================

	// the stomp bit rides with the group down the chain
	// on a miss the group being taken, or the one held, becomes stomped
	// an empty slot never carries a stomp
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			stomp_q <= 1'b0;
		end else if (step) begin
			valid_q <= in_valid;
			stomp_q <= in_valid && (in_stomp || branch_miss);
		end else if (branch_miss) begin
			stomp_q <= valid_q;
		end
	end

	// payload follows the valid bit on every step
	always_ff @(posedge clk) begin
		if (step) begin
			pc_q <= in_pc;
			sn_q <= in_sn;
		end
	end

	assign out_valid = valid_q;
	assign out_stomp = stomp_q;
	assign out_pc    = pc_q;
	assign out_sn    = sn_q;

	// a stomp mark must always sit on a real group
	a_stomp_needs_valid: assert property (
		@(posedge clk) disable iff (rst)
		out_stomp |-> out_valid
	);

endmodule

// File: design/reorder_buffer.sv
// =========================================================================
// reorder buffer
// drops stomped arrivals, stomps younger entries on a miss, commits in order
// =========================================================================

`timescale 1ns/100ps

`include "stomp_config.svh"

module reorder_buffer (
	input  logic           clk,
	input  logic           rst,
	input  logic           step,
	input  logic           branch_miss,
	input  stomp_pkg::sn_t miss_sn,
	input  logic           in_valid,
	input  stomp_pkg::pc_t in_pc,
	input  stomp_pkg::sn_t in_sn,
	input  logic           in_stomp,
	input  logic           commit_ready,
	output logic           commit_valid,
	output stomp_pkg::pc_t commit_pc,
	output stomp_pkg::sn_t commit_sn,
	output logic           commit_stomped,
	output logic           full
);

	import stomp_pkg::*;

	localparam int DEPTH = `STOMP_ROB_ENTRIES;

	// =====================================================================
	// storage and pointers
	// =====================================================================

	// per-slot state, address and age
	rob_state_e state_q [DEPTH];
	pc_t        pc_q    [DEPTH];
	sn_t        sn_q    [DEPTH];

	// head is the oldest entry and tail the next free slot
	// both wrap at DEPTH by themselves
	rob_ndx_t head_q;
	rob_ndx_t tail_q;

	// the count of occupied slots is one bit wider than the index so DEPTH fits
	logic [$clog2(DEPTH):0] count_q;

	logic enq;
	logic deq;

	// an arrival is kept only if it was not stomped in the front end
	// nothing enters in a miss cycle because that group is younger than the miss
	assign enq = step && in_valid && !in_stomp && !branch_miss;

	// the head leaves on a commit handshake
	assign deq = commit_valid && commit_ready;

	// =====================================================================
	// commit port
	// =====================================================================

	// the commit port reads straight from the head slot with no register in between
	assign commit_valid   = (state_q[head_q] != ENT_EMPTY);
	assign commit_stomped = (state_q[head_q] == ENT_STOMPED);
	assign commit_pc      = pc_q[head_q];
	assign commit_sn      = sn_q[head_q];

	assign full = (count_q == DEPTH);

	// =====================================================================
	// entry state
	// =====================================================================

	// the miss compare runs over every slot at once
	// a commit in the same cycle frees the head afterwards, so the later write wins
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				state_q[i] <= ENT_EMPTY;
			end
		end else begin
			if (branch_miss) begin
				for (int i = 0; i < DEPTH; i++) begin
					if (state_q[i] == ENT_LIVE && sn_q[i] > miss_sn) begin
						state_q[i] <= ENT_STOMPED;
					end
				end
			end
			if (enq) begin
				state_q[tail_q] <= ENT_LIVE;
			end
			if (deq) begin
				state_q[head_q] <= ENT_EMPTY;
			end
		end
	end

	// payload is written into the tail slot on every enqueue
	always_ff @(posedge clk) begin
		if (enq) begin
			pc_q[tail_q] <= in_pc;
			sn_q[tail_q] <= in_sn;
		end
	end

	// =====================================================================
	// pointers and occupancy
	// =====================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (enq) begin
				tail_q <= tail_q + 1'b1;
			end
			if (deq) begin
				head_q <= head_q + 1'b1;
			end
			// enqueue and commit together leave the count unchanged
			case ({enq, deq})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// =====================================================================
	// checks
	// =====================================================================

	// the top must stall the front end before the buffer overflows
	a_no_enq_when_full: assert property (
		@(posedge clk) disable iff (rst)
		enq |-> !full
	);

	// occupancy stays within the array
	a_count_bound: assert property (
		@(posedge clk) disable iff (rst)
		count_q <= DEPTH
	);

endmodule

// File: design/frontend_stomp_top.sv
// =========================================================================
// front-end stomp top
// fetch generator, chain of front-end stages and reorder buffer with stall
// =========================================================================

`timescale 1ns/100ps

`include "stomp_config.svh"

module frontend_stomp_top (
	input  logic           clk,
	input  logic           rst,
	input  logic           advance,
	input  logic           branch_miss,
	input  stomp_pkg::pc_t miss_pc,
	input  stomp_pkg::sn_t miss_sn,
	input  logic           commit_ready,
	output logic           commit_valid,
	output stomp_pkg::pc_t commit_pc,
	output stomp_pkg::sn_t commit_sn,
	output logic           commit_stomped,
	output logic           rob_full
);

	import stomp_pkg::*;

	localparam int STAGES = `STOMP_STAGES;

	// the whole front end moves only when the buffer has room
	logic step;

	// stage chain, index 0 is the fetch output and STAGES is the buffer input
	logic [STAGES:0] chain_valid;
	logic [STAGES:0] chain_stomp;
	pc_t             chain_pc [STAGES+1];
	sn_t             chain_sn [STAGES+1];

	assign step = advance && !rob_full;

	// fetch never emits a stomped group
	assign chain_stomp[0] = 1'b0;

	fetch_redirect u_fetch (
		.clk         (clk),
		.rst         (rst),
		.step        (step),
		.branch_miss (branch_miss),
		.miss_pc     (miss_pc),
		.out_valid   (chain_valid[0]),
		.out_pc      (chain_pc[0]),
		.out_sn      (chain_sn[0])
	);

	// =====================================================================
	// front-end stages
	// =====================================================================

	// fetch, mux, decode and rename all share the same stomp handling
	for (genvar k = 0; k < STAGES; k++) begin : g_stage
		frontend_stage u_stage (
			.clk         (clk),
			.rst         (rst),
			.step        (step),
			.branch_miss (branch_miss),
			.in_valid    (chain_valid[k]),
			.in_pc       (chain_pc[k]),
			.in_sn       (chain_sn[k]),
			.in_stomp    (chain_stomp[k]),
			.out_valid   (chain_valid[k+1]),
			.out_pc      (chain_pc[k+1]),
			.out_sn      (chain_sn[k+1]),
			.out_stomp   (chain_stomp[k+1])
		);
	end

	reorder_buffer u_rob (
		.clk            (clk),
		.rst            (rst),
		.step           (step),
		.branch_miss    (branch_miss),
		.miss_sn        (miss_sn),
		.in_valid       (chain_valid[STAGES]),
		.in_pc          (chain_pc[STAGES]),
		.in_sn          (chain_sn[STAGES]),
		.in_stomp       (chain_stomp[STAGES]),
		.commit_ready   (commit_ready),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_sn      (commit_sn),
		.commit_stomped (commit_stomped),
		.full           (rob_full)
	);

endmodule

// File: testbench/stomp_checker.sv
// =========================================================================
// front-end stomp checker
// models fetch order, front-end latency and miss windows, checks each edge
// =========================================================================

`timescale 1ns/100ps

`include "stomp_config.svh"

module stomp_checker (
	input  logic           clk,
	input  logic           rst,
	input  logic           advance,
	input  logic           branch_miss,
	input  stomp_pkg::pc_t miss_pc,
	input  stomp_pkg::sn_t miss_sn,
	input  logic           commit_ready,
	input  logic           commit_valid,
	input  stomp_pkg::pc_t commit_pc,
	input  stomp_pkg::sn_t commit_sn,
	input  logic           commit_stomped,
	input  logic           rob_full,
	output int             error_count,
	output int             check_count,
	output int             commit_count
);

	import stomp_pkg::*;

	localparam int STAGES = `STOMP_STAGES;
	localparam int DEPTH  = `STOMP_ROB_ENTRIES;

	// expected buffer contents, oldest first
	pc_t rob_pc [$];
	sn_t rob_sn [$];

	// groups still in the front end and how many steps each has seen
	pc_t flight_pc  [$];
	sn_t flight_sn  [$];
	int  flight_age [$];

	// an sn strictly between lo and hi was live when its miss came
	sn_t win_lo [$];
	sn_t win_hi [$];

	// next fetch address and the sn it will get
	pc_t fetch_pc;
	sn_t next_sn;

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("ERR t=%0t %s expected %0h actual %0h", $time, what, expected, actual);
		end
	endtask

	function automatic logic in_window(input sn_t sn);
		logic hit;
		hit = 1'b0;
		foreach (win_lo[w]) begin
			if (sn > win_lo[w] && sn < win_hi[w]) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	// =====================================================================
	// per-edge model
	// =====================================================================

	// all port values are sampled before this edge takes effect
	always @(posedge clk) begin : model_step
		logic step;
		if (rst) begin
			rob_pc.delete();
			rob_sn.delete();
			flight_pc.delete();
			flight_sn.delete();
			flight_age.delete();
			win_lo.delete();
			win_hi.delete();
			fetch_pc = '0;
			next_sn  = '0;
		end else begin
			step = advance && !rob_full;
			compare_value("commit_valid", rob_sn.size() != 0, commit_valid);
			compare_value("rob_full", rob_sn.size() == DEPTH, rob_full);
			// a head leaving on a miss edge still counts as unstomped
			if (commit_valid && commit_ready && rob_sn.size() != 0) begin
				compare_value("commit_pc", rob_pc[0], commit_pc);
				compare_value("commit_sn", rob_sn[0], commit_sn);
				compare_value("commit_stomped", in_window(rob_sn[0]), commit_stomped);
				void'(rob_pc.pop_front());
				void'(rob_sn.pop_front());
				commit_count++;
			end
			if (branch_miss) begin
				// everything in the front end dies, fetch restarts at the miss pc
				win_lo.push_back(miss_sn);
				win_hi.push_back(next_sn);
				flight_pc.delete();
				flight_sn.delete();
				flight_age.delete();
				fetch_pc = miss_pc;
			end else if (step) begin
				// the oldest group enters the buffer on its fifth step
				if (flight_age.size() != 0 && flight_age[0] == STAGES) begin
					rob_pc.push_back(flight_pc.pop_front());
					rob_sn.push_back(flight_sn.pop_front());
					void'(flight_age.pop_front());
				end
				foreach (flight_age[i]) begin
					flight_age[i]++;
				end
				flight_pc.push_back(fetch_pc);
				flight_sn.push_back(next_sn);
				flight_age.push_back(0);
				fetch_pc = fetch_pc + 1'b1;
				next_sn  = next_sn + 1'b1;
			end
		end
	end

endmodule

// File: testbench/tb_frontend_stomp.sv
// =========================================================================
// testbench for the front-end stomp logic
// applies a stimulus table on the falling edge while the checker compares
// =========================================================================

`timescale 1ns/100ps

module tb_frontend_stomp;

	import stomp_pkg::*;

	localparam int ROWS = 12;

	// how a row drives commit_ready
	localparam logic [1:0] RDY_LOW  = 2'd0;
	localparam logic [1:0] RDY_HIGH = 2'd1;
	localparam logic [1:0] RDY_RAND = 2'd2;

	logic clk;
	logic rst;
	logic advance;
	logic branch_miss;
	pc_t  miss_pc;
	sn_t  miss_sn;
	logic commit_ready;
	logic commit_valid;
	pc_t  commit_pc;
	sn_t  commit_sn;
	logic commit_stomped;
	logic rob_full;

	// counters filled in by the checker
	int error_count;
	int check_count;
	int commit_count;
	// failures that are not a wrong value
	int other_errors;

	// watchdog state
	int cycle_count;
	int cycle_limit;

	// fibonacci LFSR state for random back-pressure
	logic [7:0] lfsr;

	// stimulus table with one entry per row
	logic       row_adv  [ROWS];
	logic       row_miss [ROWS];
	pc_t        row_mpc  [ROWS];
	sn_t        row_msn  [ROWS];
	logic [1:0] row_rdy  [ROWS];
	int         row_rep  [ROWS];

	always #4 clk = ~clk;

	frontend_stomp_top u_dut (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.branch_miss    (branch_miss),
		.miss_pc        (miss_pc),
		.miss_sn        (miss_sn),
		.commit_ready   (commit_ready),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_sn      (commit_sn),
		.commit_stomped (commit_stomped),
		.rob_full       (rob_full)
	);

	stomp_checker u_chk (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.branch_miss    (branch_miss),
		.miss_pc        (miss_pc),
		.miss_sn        (miss_sn),
		.commit_ready   (commit_ready),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_sn      (commit_sn),
		.commit_stomped (commit_stomped),
		.rob_full       (rob_full),
		.error_count    (error_count),
		.check_count    (check_count),
		.commit_count   (commit_count)
	);

	// taps at bits 8, 6, 5 and 4
	// the register shifts once for every bit taken
	function automatic logic [7:0] next_lfsr(input logic [7:0] s);
		logic fb;
		fb = s[7] ^ s[5] ^ s[4] ^ s[3];
		return {s[6:0], fb};
	endfunction

	task automatic load_row(input int idx, input logic adv, input logic miss,
		input pc_t mpc, input sn_t msn, input logic [1:0] rdy, input int rep);
		row_adv[idx]  = adv;
		row_miss[idx] = miss;
		row_mpc[idx]  = mpc;
		row_msn[idx]  = msn;
		row_rdy[idx]  = rdy;
		row_rep[idx]  = rep;
	endtask

	// drives one cycle of a row right after a falling edge
	task automatic apply_row(input int idx);
		advance     = row_adv[idx];
		branch_miss = row_miss[idx];
		miss_pc     = row_mpc[idx];
		miss_sn     = row_msn[idx];
		if (row_rdy[idx] == RDY_RAND) begin
			lfsr = next_lfsr(lfsr);
			commit_ready = lfsr[0];
		end else begin
			commit_ready = (row_rdy[idx] == RDY_HIGH);
		end
	endtask

	// =====================================================================
	// watchdog
	// =====================================================================

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// =====================================================================
	// stimulus
	// =====================================================================

	initial begin
		int total;
		clk          = 1'b0;
		rst          = 1'b1;
		advance      = 1'b0;
		branch_miss  = 1'b0;
		miss_pc      = '0;
		miss_sn      = '0;
		commit_ready = 1'b0;
		lfsr         = 8'd27;
		other_errors = 0;
		cycle_count  = 0;
		// idle, straight run, fill before a miss, miss with a commit, refill
		load_row(0, 1'b0, 1'b0, 16'h0000, 8'd0, RDY_HIGH, 4);
		load_row(1, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_HIGH, 30);
		load_row(2, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_LOW, 5);
		load_row(3, 1'b1, 1'b1, 16'h0100, 8'd24, RDY_HIGH, 1);
		load_row(4, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_HIGH, 25);
		// a miss while the front end is held and then a buffer that fills up
		load_row(5, 1'b0, 1'b1, 16'h0200, 8'd52, RDY_HIGH, 1);
		load_row(6, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_LOW, 20);
		load_row(7, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_HIGH, 30);
		// random back-pressure around a third miss that hits a full buffer
		load_row(8, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_RAND, 60);
		load_row(9, 1'b1, 1'b1, 16'h0300, 8'd124, RDY_RAND, 1);
		load_row(10, 1'b1, 1'b0, 16'h0000, 8'd0, RDY_RAND, 40);
		load_row(11, 1'b0, 1'b0, 16'h0000, 8'd0, RDY_HIGH, 20);
		total = 0;
		for (int r = 0; r < ROWS; r++) begin
			total += row_rep[r];
		end
		cycle_limit = total + 200;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < ROWS; r++) begin
			for (int n = 0; n < row_rep[r]; n++) begin
				apply_row(r);
				@(negedge clk);
			end
		end

		// let the buffer empty with the front end held
		advance      = 1'b0;
		branch_miss  = 1'b0;
		commit_ready = 1'b1;
		while (commit_valid) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);

		if (commit_count == 0) begin
			$display("no instruction group was ever committed");
			other_errors++;
		end
		$display("closing: %0d checks, %0d value errors, %0d other errors",
			check_count, error_count, other_errors);
		if (error_count == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/stomp_pkg.sv
design/fetch_redirect.sv
design/frontend_stage.sv
design/reorder_buffer.sv
design/frontend_stomp_top.sv
testbench/stomp_checker.sv
testbench/tb_frontend_stomp.sv
